/* rtl/simd_sb_pkg.sv */
// Shared types and default sizes for the SIMD write-back scoreboard
// Latencies, including DIV_LAT, must fit in STAGES_W bits

package simd_sb_pkg;

    // Element width, encoded as in vtype.vsew
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    // Operation class, already decoded upstream
    // Divider classes share bit 2; bit 0 separates signed from unsigned
    typedef enum logic [2:0] {
        OP_SIMPLE = 3'd0,
        OP_MUL    = 3'd1,   // Widening and high multiplies
        OP_MACC   = 3'd2,   // Multiply-accumulate and saturating multiply
        OP_RED    = 3'd3,   // Reductions
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } simd_op_t;

    localparam int STAGES_W = 6;    // Width of a latency value

    // Default sizes for the top level
    localparam int DEF_VL_W    = 7;     // Vector lengths up to 64
    localparam int DEF_DATA_W  = 64;
    localparam int DEF_XLEN    = 64;
    localparam int DEF_DIV_LAT = 32;
    localparam int DEF_MAX_LAT = 8;     // Longest fixed latency

    // True for the classes that run on the shared iterative divider
    function automatic logic is_div_op(simd_op_t op);
        logic res;
        res = (op == OP_DIV) || (op == OP_DIVU) ||
              (op == OP_REM) || (op == OP_REMU);
        return res;
    endfunction

endpackage

/* rtl/simd_fixed_lat_tracker.sv */
// Write-back slot reservations for fixed-latency results
// A flush drops every reservation, including one issued in the same cycle
// lat_i outside 1..MAX_LAT reserves nothing

module simd_fixed_lat_tracker #(
    parameter int MAX_LAT = simd_sb_pkg::DEF_MAX_LAT
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              flush_i,
    input  logic                              issue_i,
    input  logic [simd_sb_pkg::STAGES_W-1:0]  lat_i,
    output logic [MAX_LAT:0]                  slot_busy_o,
    output logic                              wb_o
);
    import simd_sb_pkg::*;

    // Bit k set: a result reaches the port k cycles after the current one
    logic [MAX_LAT-1:0] res_q;
    logic [MAX_LAT-1:0] res_d;

    always_comb begin
        res_d = {1'b0, res_q[MAX_LAT-1:1]};    // Everything moves one cycle closer

        // A result of latency L is on the port L-1 cycles after the next edge
        if (issue_i) begin
            for (int k = 0; k < MAX_LAT; k++) begin
                if (lat_i == STAGES_W'(k + 1)) begin
                    res_d[k] = 1'b1;
                end
            end
        end

        if (flush_i) begin
            res_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            res_q <= '0;
        end else begin
            res_q <= res_d;
        end
    end

    // Seen from a candidate issuing now, slot k of the stored vector
    // lines up with latency k; nothing is ever held MAX_LAT cycles out
    assign slot_busy_o = {1'b0, res_q};

    assign wb_o = res_q[0];     // Result on the port this cycle

endmodule

/* rtl/simd_div_tracker.sv */
// Occupancy and operand memory of the shared iterative divider
// issue_i marks every accepted divide or remainder, reuse hits included
// DIV_LAT must fit in STAGES_W bits; no flush, the divider runs to completion

module simd_div_tracker #(
    parameter int DATA_W  = simd_sb_pkg::DEF_DATA_W,
    parameter int XLEN    = simd_sb_pkg::DEF_XLEN,
    parameter int DIV_LAT = simd_sb_pkg::DEF_DIV_LAT
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              issue_i,
    input  simd_sb_pkg::simd_op_t             op_i,
    input  logic                              is_opvx_i,
    input  logic [DATA_W-1:0]                 vs1_i,
    input  logic [DATA_W-1:0]                 vs2_i,
    input  logic [XLEN-1:0]                   rs1_i,
    output logic                              reuse_o,
    output logic                              busy_o,
    output logic [simd_sb_pkg::STAGES_W-1:0]  remaining_o,
    output logic                              wb_o
);
    import simd_sb_pkg::*;

    // Previous divide or remainder
    simd_op_t           prev_op_q;
    logic               prev_opvx_q;
    logic [DATA_W-1:0]  prev_vs1_q;
    logic [DATA_W-1:0]  prev_vs2_q;
    logic [XLEN-1:0]    prev_rs1_q;

    logic [STAGES_W-1:0] cnt_q;    // Cycles until write-back, 0 when idle

    logic type_hit;
    logic src1_hit;

    // Same type, or the DIV/REM partner of the same signedness.
    // With the class encoding that is both on the divider and equal bit 0
    assign type_hit = is_div_op(op_i) && is_div_op(prev_op_q) &&
                      (op_i[0] == prev_op_q[0]);

    // Scalar operand replaces vs1 for the .vx forms
    assign src1_hit = is_opvx_i ? (rs1_i == prev_rs1_q) : (vs1_i == prev_vs1_q);

    assign reuse_o = type_hit && (is_opvx_i == prev_opvx_q) &&
                     (vs2_i == prev_vs2_q) && src1_hit;

    // Operand memory, cleared to a state that can never hit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prev_op_q   <= OP_SIMPLE;
            prev_opvx_q <= 1'b0;
            prev_vs1_q  <= '0;
            prev_vs2_q  <= '0;
            prev_rs1_q  <= '0;
        end else if (issue_i) begin
            prev_op_q   <= op_i;
            prev_opvx_q <= is_opvx_i;
            prev_vs1_q  <= vs1_i;
            prev_vs2_q  <= vs2_i;
            prev_rs1_q  <= rs1_i;
        end
    end

    // Occupancy counter, a reuse hit never starts the divider
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (issue_i && !reuse_o) begin
            cnt_q <= STAGES_W'(DIV_LAT);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - STAGES_W'(1);
        end
    end

    assign busy_o      = (cnt_q != '0);    // Held through the write-back cycle
    assign remaining_o = cnt_q;
    assign wb_o        = (cnt_q == STAGES_W'(1));

endmodule

/* rtl/simd_issue_arbiter.sv */
// Latency decode and issue decision for one candidate per cycle
// Purely combinational; the candidate is held by the source while stalled
// vl_i above 64 is treated as the longest reduction band

module simd_issue_arbiter #(
    parameter int VL_W    = simd_sb_pkg::DEF_VL_W,
    parameter int MAX_LAT = simd_sb_pkg::DEF_MAX_LAT,
    parameter int DIV_LAT = simd_sb_pkg::DEF_DIV_LAT
) (
    input  logic                              ready_i,
    input  simd_sb_pkg::simd_op_t             op_i,
    input  simd_sb_pkg::sew_t                 sew_i,
    input  logic [VL_W-1:0]                   vl_i,
    input  logic [MAX_LAT:0]                  slot_busy_i,
    input  logic                              div_busy_i,
    input  logic                              div_reuse_i,
    input  logic [simd_sb_pkg::STAGES_W-1:0]  div_remaining_i,
    output logic [simd_sb_pkg::STAGES_W-1:0]  exe_stages_o,
    output logic                              stall_o,
    output logic                              fix_issue_o,
    output logic [simd_sb_pkg::STAGES_W-1:0]  fix_lat_o,
    output logic                              div_issue_o
);
    import simd_sb_pkg::*;

    logic [STAGES_W-1:0] red_lat;
    logic [STAGES_W-1:0] lat;
    logic                is_div;
    logic                div_long;     // Needs the divider itself
    logic                slot_hit;
    logic                div_wb_hit;
    logic                stall;
    logic                accept;

    // Reduction tree depth grows with log2 of the vector length
    always_comb begin
        if (vl_i <= 1) begin
            red_lat = STAGES_W'(2);
        end else if (vl_i == 2) begin
            red_lat = STAGES_W'(3);
        end else if (vl_i <= 4) begin
            red_lat = STAGES_W'(4);
        end else if (vl_i <= 8) begin
            red_lat = STAGES_W'(5);
        end else if (vl_i <= 16) begin
            red_lat = STAGES_W'(6);
        end else if (vl_i <= 32) begin
            red_lat = STAGES_W'(7);
        end else begin
            red_lat = STAGES_W'(8);
        end
    end

    always_comb begin
        case (op_i)
            OP_SIMPLE: lat = STAGES_W'(1);
            OP_MUL:    lat = (sew_i == SEW_64) ? STAGES_W'(3) : STAGES_W'(2);
            OP_MACC:   lat = (sew_i == SEW_64) ? STAGES_W'(4) : STAGES_W'(3);
            OP_RED:    lat = red_lat;
            default:   lat = div_reuse_i ? STAGES_W'(1) : STAGES_W'(DIV_LAT); // Divider
        endcase
    end

    assign is_div   = is_div_op(op_i);
    assign div_long = is_div && !div_reuse_i;

    // Port already reserved at the candidate's write-back cycle
    always_comb begin
        slot_hit = 1'b0;
        for (int k = 0; k <= MAX_LAT; k++) begin
            if ((lat == STAGES_W'(k)) && slot_busy_i[k]) begin
                slot_hit = 1'b1;
            end
        end
    end

    // Divider result lands on the same cycle
    // The count is 1 in the divider's write-back cycle, so it leads the latency by one
    assign div_wb_hit = (div_remaining_i == lat + STAGES_W'(1));

    // Only one divide at a time, even when the result could be reused
    assign stall  = ready_i && (slot_hit || div_wb_hit || (is_div && div_busy_i));
    assign accept = ready_i && !stall;

    assign exe_stages_o = lat;
    assign stall_o      = stall;

    // Reuse hits go through the slot vector like any latency-1 op
    assign fix_issue_o = accept && !div_long;
    assign fix_lat_o   = lat;

    // The divider tracker sees every accepted divide to record its operands
    assign div_issue_o = accept && is_div;

endmodule

/* rtl/simd_score_board.sv */
// Write-back scoreboard for the SIMD unit with a single write-back port
// One candidate per cycle; stall_o is the only back-pressure
// DIV_LAT must exceed MAX_LAT and fit in STAGES_W bits

module simd_score_board #(
    parameter int VL_W    = simd_sb_pkg::DEF_VL_W,
    parameter int DATA_W  = simd_sb_pkg::DEF_DATA_W,
    parameter int XLEN    = simd_sb_pkg::DEF_XLEN,
    parameter int MAX_LAT = simd_sb_pkg::DEF_MAX_LAT,
    parameter int DIV_LAT = simd_sb_pkg::DEF_DIV_LAT
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              flush_i,     // One-cycle pulse
    input  logic                              ready_i,     // Candidate present
    input  simd_sb_pkg::simd_op_t             op_i,
    input  simd_sb_pkg::sew_t                 sew_i,
    input  logic [VL_W-1:0]                   vl_i,
    input  logic                              is_opvx_i,   // rs1_i replaces vs1_i
    input  logic [DATA_W-1:0]                 vs1_i,
    input  logic [DATA_W-1:0]                 vs2_i,
    input  logic [XLEN-1:0]                   rs1_i,
    output logic [simd_sb_pkg::STAGES_W-1:0]  exe_stages_o,
    output logic                              stall_o,
    output logic                              wb_valid_o,
    output logic                              wb_div_o
);
    import simd_sb_pkg::*;

    logic                fix_issue;
    logic [STAGES_W-1:0] fix_lat;
    logic [MAX_LAT:0]    slot_busy;
    logic                fix_wb;
    logic                div_issue;
    logic                div_busy;
    logic                div_reuse;
    logic [STAGES_W-1:0] div_remaining;
    logic                div_wb;

    simd_fixed_lat_tracker #(
        .MAX_LAT (MAX_LAT)
    ) u_fixed (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .issue_i     (fix_issue),
        .lat_i       (fix_lat),
        .slot_busy_o (slot_busy),
        .wb_o        (fix_wb)
    );

    simd_div_tracker #(
        .DATA_W  (DATA_W),
        .XLEN    (XLEN),
        .DIV_LAT (DIV_LAT)
    ) u_div (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .issue_i     (div_issue),
        .op_i        (op_i),
        .is_opvx_i   (is_opvx_i),
        .vs1_i       (vs1_i),
        .vs2_i       (vs2_i),
        .rs1_i       (rs1_i),
        .reuse_o     (div_reuse),
        .busy_o      (div_busy),
        .remaining_o (div_remaining),
        .wb_o        (div_wb)
    );

    simd_issue_arbiter #(
        .VL_W    (VL_W),
        .MAX_LAT (MAX_LAT),
        .DIV_LAT (DIV_LAT)
    ) u_arb (
        .ready_i         (ready_i),
        .op_i            (op_i),
        .sew_i           (sew_i),
        .vl_i            (vl_i),
        .slot_busy_i     (slot_busy),
        .div_busy_i      (div_busy),
        .div_reuse_i     (div_reuse),
        .div_remaining_i (div_remaining),
        .exe_stages_o    (exe_stages_o),
        .stall_o         (stall_o),
        .fix_issue_o     (fix_issue),
        .fix_lat_o       (fix_lat),
        .div_issue_o     (div_issue)
    );

    // Stall logic keeps the two strobes apart
    assign wb_valid_o = fix_wb | div_wb;
    assign wb_div_o   = div_wb;

endmodule

/* testbench/tb_clock_gen.sv */
// Free-running clock and active-low reset for the testbench
// Reset is released on a falling edge after RST_CYCLES rising edges

module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);       // Release away from the sampling edge
        rstn_o = 1'b1;
    end

endmodule

/* testbench/tb_simd_score_board.sv */
// Replays testbench/simd_sb_input.txt, one line per cycle; run from the project root
// The divider latency is shortened to 12 so the divide tests stay short

module tb_simd_score_board;
    import simd_sb_pkg::*;

    localparam int    PERIOD    = 100;
    localparam int    DIV_LAT   = 12;
    localparam int    MAX_LINES = 256;
    localparam string STIM_FILE = "testbench/simd_sb_input.txt";

    logic                clk;
    logic                rstn;
    logic                flush;
    logic                ready;
    simd_op_t            op;
    sew_t                sew;
    logic [6:0]          vl;
    logic                is_opvx;
    logic [63:0]         vs1;
    logic [63:0]         vs2;
    logic [63:0]         rs1;
    logic [STAGES_W-1:0] exe_stages;
    logic                stall;
    logic                wb_valid;
    logic                wb_div;

    // One entry per stimulus line
    logic [7:0]  t_num   [0:MAX_LINES-1];
    logic [7:0]  t_flush [0:MAX_LINES-1];
    logic [7:0]  t_ready [0:MAX_LINES-1];
    logic [7:0]  t_op    [0:MAX_LINES-1];
    logic [7:0]  t_sew   [0:MAX_LINES-1];
    logic [7:0]  t_vl    [0:MAX_LINES-1];
    logic [7:0]  t_opvx  [0:MAX_LINES-1];
    logic [63:0] t_vs1   [0:MAX_LINES-1];
    logic [63:0] t_vs2   [0:MAX_LINES-1];
    logic [63:0] t_rs1   [0:MAX_LINES-1];
    logic [7:0]  x_exe   [0:MAX_LINES-1];
    logic [7:0]  x_stall [0:MAX_LINES-1];
    logic [7:0]  x_wbv   [0:MAX_LINES-1];
    logic [7:0]  x_wbd   [0:MAX_LINES-1];

    int n_lines      = 0;
    int load_errors  = 0;
    int test_errors  = 0;   // Errors of the test that is running
    int total_errors = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int test_cycles  = 0;
    int cycle_cnt    = 0;
    int cycle_limit  = 0;
    bit loaded       = 1'b0;

    tb_clock_gen #(
        .PERIOD     (PERIOD),
        .RST_CYCLES (5)
    ) u_clk (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    simd_score_board #(
        .VL_W    (7),
        .DATA_W  (64),
        .XLEN    (64),
        .MAX_LAT (8),
        .DIV_LAT (DIV_LAT)
    ) uut (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .flush_i      (flush),
        .ready_i      (ready),
        .op_i         (op),
        .sew_i        (sew),
        .vl_i         (vl),
        .is_opvx_i    (is_opvx),
        .vs1_i        (vs1),
        .vs2_i        (vs2),
        .rs1_i        (rs1),
        .exe_stages_o (exe_stages),
        .stall_o      (stall),
        .wb_valid_o   (wb_valid),
        .wb_div_o     (wb_div)
    );

    function automatic string test_name(int num);
        case (num)
            1:       return "latency decode";
            2:       return "port conflict";
            3:       return "divider occupancy";
            4:       return "divide result reuse";
            5:       return "flush";
            default: return "unnamed";
        endcase
    endfunction

    task read_stimulus();
        int    fd;
        int    cnt;
        int    line_no;
        string line;
        fd      = $fopen(STIM_FILE, "r");
        line_no = 0;
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            load_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;   // Blank or comment line
            end
            if (n_lines >= MAX_LINES) begin
                $display("Stimulus file has more than %0d lines", MAX_LINES);
                load_errors++;
                break;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          t_num[n_lines], t_flush[n_lines], t_ready[n_lines],
                          t_op[n_lines], t_sew[n_lines], t_vl[n_lines],
                          t_opvx[n_lines], t_vs1[n_lines], t_vs2[n_lines],
                          t_rs1[n_lines], x_exe[n_lines], x_stall[n_lines],
                          x_wbv[n_lines], x_wbd[n_lines]);
            if (cnt != 14) begin
                $display("Stimulus file line %0d is malformed: %0d of 14 fields read",
                         line_no, cnt);
                load_errors++;
            end else begin
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0 && load_errors == 0) begin
            $display("Stimulus file holds no test lines");
            load_errors++;
        end
    endtask

    task automatic drive_idle();
        flush   = 1'b0;
        ready   = 1'b0;
        op      = OP_SIMPLE;
        sew     = SEW_8;
        vl      = '0;
        is_opvx = 1'b0;
        vs1     = '0;
        vs2     = '0;
        rs1     = '0;
    endtask

    task automatic apply_line(int i);
        flush   = t_flush[i][0];
        ready   = t_ready[i][0];
        op      = simd_op_t'(t_op[i][2:0]);
        sew     = sew_t'(t_sew[i][1:0]);
        vl      = t_vl[i][6:0];
        is_opvx = t_opvx[i][0];
        vs1     = t_vs1[i];
        vs2     = t_vs2[i];
        rs1     = t_rs1[i];
    endtask

    task automatic expect_value(string name, logic [63:0] got, logic [63:0] exp, int i);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at time %0t: line %0d of test %0d, %s is %0h, expected %0h",
                     $time, i, t_num[i], name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_line(int i);
        expect_value("exe_stages_o", exe_stages, x_exe[i], i);
        expect_value("stall_o", stall, x_stall[i], i);
        expect_value("wb_valid_o", wb_valid, x_wbv[i], i);
        expect_value("wb_div_o", wb_div, x_wbd[i], i);
    endtask

    task automatic close_test(int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d, %s: %0d cycles, clean", num, test_name(num), test_cycles);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: %0d cycles, %0d errors",
                     num, test_name(num), test_cycles, test_errors);
        end
        total_errors += test_errors;
        test_errors   = 0;
        test_cycles   = 0;
    endtask

    // Watchdog, ends the run if the replay does not finish in time
    initial begin
        wait (loaded);
        while (cycle_cnt <= cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        drive_idle();
        read_stimulus();
        cycle_limit = n_lines + DIV_LAT + 20;
        loaded      = 1'b1;
        if (load_errors == 0) begin
            wait (rstn === 1'b1);
            for (int i = 0; i < n_lines; i++) begin
                @(negedge clk);
                apply_line(i);
                #(PERIOD * 2 / 5);     // Just before the next rising edge
                check_line(i);
                test_cycles++;
                if (i == n_lines - 1 || t_num[i + 1] != t_num[i]) begin
                    close_test(t_num[i]);
                end
            end
        end
        $display("Tests run: %0d, failed: %0d; checks: %0d, errors: %0d, file errors: %0d",
                 tests_run, tests_failed, checks, total_errors, load_errors);
        if (total_errors == 0 && load_errors == 0 && tests_run > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* testbench/simd_sb_input.txt */
# test flush ready op sew vl opvx vs1 vs2 rs1 | exe stall wb_valid wb_div, all hex
# op: 0 simple 1 mul 2 macc 3 red 4 div 5 divu 6 rem 7 remu; sew 0..3 is 8..64 bits
1 0 1 0 0 00 0 00 00 00 01 0 0 0
1 0 1 0 3 00 0 00 00 00 01 0 1 0
1 0 1 1 0 00 0 00 00 00 02 0 1 0
1 0 1 1 1 00 0 00 00 00 02 0 0 0
1 0 1 1 2 00 0 00 00 00 02 0 1 0
1 0 1 3 0 01 0 00 00 00 02 0 1 0
1 0 1 1 3 00 0 00 00 00 03 0 1 0
1 0 1 2 0 00 0 00 00 00 03 0 1 0
1 0 1 2 1 00 0 00 00 00 03 0 0 0
1 0 1 2 2 00 0 00 00 00 03 0 1 0
1 0 1 3 0 02 0 00 00 00 03 0 1 0
1 0 1 2 3 00 0 00 00 00 04 0 1 0
1 0 1 3 0 03 0 00 00 00 04 0 1 0
1 0 1 3 0 08 0 00 00 00 05 0 1 0
1 0 1 3 0 09 0 00 00 00 06 0 0 0
1 0 1 3 0 20 0 00 00 00 07 0 1 0
1 0 1 3 0 40 0 00 00 00 08 0 1 0
1 0 0 0 0 00 0 00 00 00 01 0 0 0
1 0 0 0 0 00 0 00 00 00 01 0 1 0
1 0 0 0 0 00 0 00 00 00 01 0 0 0
1 0 0 0 0 00 0 00 00 00 01 0 1 0
1 0 0 0 0 00 0 00 00 00 01 0 0 0
1 0 0 0 0 00 0 00 00 00 01 0 1 0
1 0 0 0 0 00 0 00 00 00 01 0 0 0
1 0 0 0 0 00 0 00 00 00 01 0 1 0
2 0 1 2 0 00 0 00 00 00 03 0 0 0
2 0 1 1 0 00 0 00 00 00 02 1 0 0
2 0 1 1 0 00 0 00 00 00 02 0 0 0
2 0 0 0 0 00 0 00 00 00 01 0 1 0
2 0 0 0 0 00 0 00 00 00 01 0 1 0
3 0 1 4 3 00 0 15 2a 00 0c 0 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 0 0
3 0 1 4 3 00 1 07 31 05 0c 1 1 1
3 0 1 4 3 00 1 07 31 05 0c 0 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 0 0
4 0 1 6 3 00 1 00 31 05 01 1 1 1
4 0 1 6 3 00 1 00 31 05 01 0 0 0
4 0 1 7 3 00 1 00 31 05 0c 0 1 0
5 0 1 2 3 00 0 00 00 00 04 0 0 0
5 0 1 3 0 40 0 00 00 00 08 0 0 0
5 1 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 0 0
5 0 0 0 0 00 0 00 00 00 01 0 1 1
5 0 0 0 0 00 0 00 00 00 01 0 0 0

/* src.f */
rtl/simd_sb_pkg.sv
rtl/simd_fixed_lat_tracker.sv
rtl/simd_div_tracker.sv
rtl/simd_issue_arbiter.sv
rtl/simd_score_board.sv
testbench/tb_clock_gen.sv
testbench/tb_simd_score_board.sv

/* Bender.yml */
package:
  name: simd_score_board

sources:
  - files:
      - rtl/simd_sb_pkg.sv
      - rtl/simd_fixed_lat_tracker.sv
      - rtl/simd_div_tracker.sv
      - rtl/simd_issue_arbiter.sv
      - rtl/simd_score_board.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_simd_score_board.sv
